/* hdl/paint_cfg.svh */
`ifndef PAINT_CFG_SVH
`define PAINT_CFG_SVH

// Canvas geometry. The palette uses the same grid.
`define PAINT_DIM     16
`define PAINT_COORD_W 4

// XOR mask applied to the pixel under the cursor in every scan.
`define PAINT_HILITE  8'hFF

// Key codes. Codes 6 and 7 are accepted but only trigger a redraw.
`define PAINT_KEY_UP    3'd0
`define PAINT_KEY_DOWN  3'd1
`define PAINT_KEY_LEFT  3'd2
`define PAINT_KEY_RIGHT 3'd3
`define PAINT_KEY_C     3'd4
`define PAINT_KEY_ENTER 3'd5

`endif

/* hdl/paint_pkg.sv */
`default_nettype none

package paint_pkg;

    `include "paint_cfg.svh"

    typedef logic [`PAINT_COORD_W-1:0]   coord_t;
    typedef logic [2*`PAINT_COORD_W-1:0] color_t; // A palette colour is x and y joined.
    typedef logic [2:0]                  key_t;

    typedef enum logic [3:0] {
        START               = 4'b0000,
        INIT                = 4'b0001,
        CHECK_C             = 4'b0010,
        CHECK_ENTER         = 4'b0011,
        CURSOR_PALETTE      = 4'b0100,
        CHECK_ENTER_PALETTE = 4'b0101,
        CHANGE_COLOR        = 4'b0110,
        DRAW_CURSOR         = 4'b0111,
        PAINT               = 4'b1000
    } paint_state_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        color_t color;
    } pixel_wr_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        color_t color;
        logic   last;
    } pixel_out_t;

    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
    } cursor_step_t;

endpackage

`default_nettype wire

/* hdl/key_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "paint_cfg.svh"

module key_decoder import paint_pkg::*; (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire key_t         key,
    input  wire logic         key_valid,
    input  wire logic         comp_c,
    input  wire logic         comp_enter,
    input  wire logic         comp_palette,
    input  wire logic         comp_key,
    output cursor_step_t      step,
    output logic              c_pending,
    output logic              enter_pending,
    output logic              key_pending
);

    // A new key wins over a clear in the same cycle, so no event is lost.
    always_ff @(posedge clk) begin
        if (rst) begin
            step          <= '0;
            c_pending     <= 1'b0;
            enter_pending <= 1'b0;
            key_pending   <= 1'b1; // Forces the first canvas scan.
        end else begin
            step <= '0;
            if (comp_c) c_pending <= 1'b0;
            if (comp_enter || comp_palette) enter_pending <= 1'b0;
            if (comp_key || comp_palette) key_pending <= 1'b0;

            if (key_valid) begin
                key_pending <= 1'b1;
                case (key)
                    `PAINT_KEY_UP:    step.up    <= 1'b1;
                    `PAINT_KEY_DOWN:  step.down  <= 1'b1;
                    `PAINT_KEY_LEFT:  step.left  <= 1'b1;
                    `PAINT_KEY_RIGHT: step.right <= 1'b1;
                    `PAINT_KEY_C:     c_pending     <= 1'b1;
                    `PAINT_KEY_ENTER: enter_pending <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // The controller checks one flag per state, so its pulses never overlap.
    a_one_check: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({comp_c, comp_enter, comp_palette, comp_key})
    );

endmodule

`default_nettype wire

/* hdl/cursor_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "paint_cfg.svh"

module cursor_tracker import paint_pkg::*; (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire cursor_step_t step,
    output coord_t            cur_x,
    output coord_t            cur_y
);

    localparam coord_t EDGE = coord_t'(`PAINT_DIM - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            cur_x <= '0;
            cur_y <= '0;
        end else begin
            // Row 0 is the top of the canvas.
            if (step.up && cur_y != '0) begin
                cur_y <= cur_y - 1'b1;
            end else if (step.down && cur_y != EDGE) begin
                cur_y <= cur_y + 1'b1;
            end

            if (step.left && cur_x != '0) begin
                cur_x <= cur_x - 1'b1;
            end else if (step.right && cur_x != EDGE) begin
                cur_x <= cur_x + 1'b1;
            end
        end
    end

    // A step at an edge leaves the cursor there instead of wrapping it to the far side.
    a_in_canvas: assert property (
        @(posedge clk) disable iff (rst)
        !($past(cur_x) == EDGE && cur_x == '0) && !($past(cur_x) == '0 && cur_x == EDGE) &&
        !($past(cur_y) == EDGE && cur_y == '0) && !($past(cur_y) == '0 && cur_y == EDGE)
    );

endmodule

`default_nettype wire

/* hdl/control_paint.sv */
`timescale 1ns/1ps
`default_nettype none

module control_paint import paint_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   clear_done,
    input  wire coord_t cur_x,
    input  wire coord_t cur_y,
    input  wire logic   c_pending,
    input  wire logic   enter_pending,
    input  wire logic   key_pending,
    input  wire logic   scan_done,
    output logic        comp_c,
    output logic        comp_enter,
    output logic        comp_palette,
    output logic        comp_key,
    output pixel_wr_t   wr,
    output logic        wr_en,
    output logic        scan_start,
    output logic        scan_palette
);

    paint_state_t state;
    color_t       color;
    coord_t       pos_x; // Cursor as seen when the command was taken.
    coord_t       pos_y;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= START;
            color <= '0;
        end else begin
            case (state)
                START: begin
                    if (clear_done) state <= INIT; // Canvas memory is zeroed.
                end

                INIT: begin
                    pos_x <= cur_x;
                    pos_y <= cur_y;
                    if (key_pending) state <= CHECK_C;
                end

                CHECK_C: begin
                    state <= c_pending ? CURSOR_PALETTE : CHECK_ENTER;
                end

                CHECK_ENTER: begin
                    state <= enter_pending ? PAINT : DRAW_CURSOR;
                end

                // The write itself is the decoded wr_en; redraw after it.
                PAINT: begin
                    state <= CHECK_C;
                end

                DRAW_CURSOR: begin
                    if (scan_done) state <= INIT;
                end

                CURSOR_PALETTE: begin
                    if (scan_done) state <= CHECK_ENTER_PALETTE;
                end

                // Any other key in the palette only moves the highlight.
                CHECK_ENTER_PALETTE: begin
                    if (key_pending) begin
                        state <= enter_pending ? CHANGE_COLOR : CURSOR_PALETTE;
                    end
                end

                CHANGE_COLOR: begin
                    color <= {cur_x, cur_y};
                    state <= CHECK_C;
                end

                default: state <= START;
            endcase
        end
    end

    always_comb begin
        comp_c       = 1'b0;
        comp_enter   = 1'b0;
        comp_palette = 1'b0;
        comp_key     = 1'b0;
        wr_en        = 1'b0;
        scan_start   = 1'b0;
        scan_palette = 1'b0;
        case (state)
            INIT:                comp_key     = 1'b1;
            CHECK_C:             comp_c       = 1'b1;
            CHECK_ENTER:         comp_enter   = 1'b1;
            CHECK_ENTER_PALETTE: comp_palette = 1'b1;
            PAINT:               wr_en        = 1'b1;
            DRAW_CURSOR:         scan_start   = 1'b1;
            CURSOR_PALETTE: begin
                scan_start   = 1'b1;
                scan_palette = 1'b1;
            end
            default: ;
        endcase
    end

    assign wr = '{x: pos_x, y: pos_y, color: color};

    a_single_write: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |=> !wr_en
    );

endmodule

`default_nettype wire

/* hdl/frame_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "paint_cfg.svh"

module frame_buffer import paint_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire pixel_wr_t wr,
    input  wire logic      wr_en,
    input  wire coord_t    rd_x,
    input  wire coord_t    rd_y,
    output color_t         rd_color,
    output logic           clear_done
);

    localparam int DEPTH = `PAINT_DIM * `PAINT_DIM;

    color_t                      mem [DEPTH];
    logic [2*`PAINT_COORD_W-1:0] clr_addr;

    // After reset one entry is zeroed per cycle until the whole canvas is blank.
    always_ff @(posedge clk) begin
        if (rst) begin
            clr_addr   <= '0;
            clear_done <= 1'b0;
        end else if (!clear_done) begin
            clr_addr <= clr_addr + 1'b1;
            if (clr_addr == '1) clear_done <= 1'b1;
        end
    end

    // Entries are stored row by row.
    always_ff @(posedge clk) begin
        if (!clear_done) begin
            mem[clr_addr] <= '0;
        end else if (wr_en) begin
            mem[{wr.y, wr.x}] <= wr.color;
        end
        rd_color <= mem[{rd_y, rd_x}];
    end

endmodule

`default_nettype wire

/* hdl/frame_scanner.sv */
`timescale 1ns/1ps
`default_nettype none

`include "paint_cfg.svh"

module frame_scanner import paint_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   scan_start,
    input  wire logic   scan_palette,
    input  wire coord_t cur_x,
    input  wire coord_t cur_y,
    output coord_t      rd_x,
    output coord_t      rd_y,
    input  wire color_t rd_color,
    output pixel_out_t  pix,
    output logic        pix_valid,
    output logic        scan_done
);

    logic [2*`PAINT_COORD_W-1:0] addr; // Row in the upper half, so y is the outer loop.
    logic                        busy;
    logic                        palette_q;
    logic                        idle;

    // The second stage lines up with the registered memory read.
    coord_t s2_x;
    coord_t s2_y;
    logic   s2_last;
    logic   s2_hit;
    color_t base;

    assign rd_x = addr[`PAINT_COORD_W-1:0];
    assign rd_y = addr[2*`PAINT_COORD_W-1:`PAINT_COORD_W];

    // The start level is still high while the last pixel and done go out.
    assign idle = !busy && !pix_valid && !scan_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            pix_valid <= 1'b0;
            scan_done <= 1'b0;
        end else begin
            pix_valid <= busy;
            scan_done <= pix_valid && s2_last;
            if (idle && scan_start) begin
                busy <= 1'b1;
            end else if (busy && addr == '1) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (idle && scan_start) begin
            addr      <= '0;
            palette_q <= scan_palette;
        end else if (busy) begin
            addr <= addr + 1'b1;
        end
        s2_x    <= rd_x;
        s2_y    <= rd_y;
        s2_last <= addr == '1;
        s2_hit  <= rd_x == cur_x && rd_y == cur_y;
    end

    assign base = palette_q ? {s2_x, s2_y} : rd_color;

    assign pix = '{
        x:     s2_x,
        y:     s2_y,
        color: s2_hit ? base ^ `PAINT_HILITE : base,
        last:  s2_last
    };

endmodule

`default_nettype wire

/* hdl/paint_top.sv */
`timescale 1ns/1ps
`default_nettype none

module paint_top import paint_pkg::*; (
    input  wire logic clk,
    input  wire logic rst,
    input  wire key_t key,
    input  wire logic key_valid,
    output pixel_out_t pix,
    output logic      pix_valid,
    output logic      scan_done
);

    cursor_step_t step;
    logic         c_pending;
    logic         enter_pending;
    logic         key_pending;
    logic         comp_c;
    logic         comp_enter;
    logic         comp_palette;
    logic         comp_key;
    coord_t       cur_x;
    coord_t       cur_y;
    pixel_wr_t    wr;
    logic         wr_en;
    logic         scan_start;
    logic         scan_palette;
    logic         clear_done;
    coord_t       rd_x;
    coord_t       rd_y;
    color_t       rd_color;

    key_decoder i_key_decoder (
        .clk           (clk),
        .rst           (rst),
        .key           (key),
        .key_valid     (key_valid),
        .comp_c        (comp_c),
        .comp_enter    (comp_enter),
        .comp_palette  (comp_palette),
        .comp_key      (comp_key),
        .step          (step),
        .c_pending     (c_pending),
        .enter_pending (enter_pending),
        .key_pending   (key_pending)
    );

    cursor_tracker i_cursor_tracker (
        .clk   (clk),
        .rst   (rst),
        .step  (step),
        .cur_x (cur_x),
        .cur_y (cur_y)
    );

    control_paint i_control_paint (
        .clk           (clk),
        .rst           (rst),
        .clear_done    (clear_done),
        .cur_x         (cur_x),
        .cur_y         (cur_y),
        .c_pending     (c_pending),
        .enter_pending (enter_pending),
        .key_pending   (key_pending),
        .scan_done     (scan_done),
        .comp_c        (comp_c),
        .comp_enter    (comp_enter),
        .comp_palette  (comp_palette),
        .comp_key      (comp_key),
        .wr            (wr),
        .wr_en         (wr_en),
        .scan_start    (scan_start),
        .scan_palette  (scan_palette)
    );

    frame_buffer i_frame_buffer (
        .clk        (clk),
        .rst        (rst),
        .wr         (wr),
        .wr_en      (wr_en),
        .rd_x       (rd_x),
        .rd_y       (rd_y),
        .rd_color   (rd_color),
        .clear_done (clear_done)
    );

    frame_scanner i_frame_scanner (
        .clk          (clk),
        .rst          (rst),
        .scan_start   (scan_start),
        .scan_palette (scan_palette),
        .cur_x        (cur_x),
        .cur_y        (cur_y),
        .rd_x         (rd_x),
        .rd_y         (rd_y),
        .rd_color     (rd_color),
        .pix          (pix),
        .pix_valid    (pix_valid),
        .scan_done    (scan_done)
    );

endmodule

`default_nettype wire

/* verif/tb_paint.sv */
`timescale 1ns/1ps
`default_nettype none

`include "paint_cfg.svh"

module tb_paint import paint_pkg::*; ();

    localparam int RANDOM_KEYS    = 400;
    localparam int KEY_BUDGET     = RANDOM_KEYS + 100; // Directed keys fit in the extra 100.
    localparam int CYCLES_PER_KEY = 700;
    // One more slot covers the canvas clear and the first scan after reset.
    localparam int MAX_CYCLES     = (KEY_BUDGET + 1) * CYCLES_PER_KEY;
    localparam int PIXELS         = `PAINT_DIM * `PAINT_DIM;
    localparam logic [31:0] SEED  = 32'h329abbcd;

    logic       clk = 1'b0;
    logic       rst;
    key_t       key;
    logic       key_valid;
    pixel_out_t pix;
    logic       pix_valid;
    logic       scan_done;

    // Reference model of the paint program.
    color_t      canvas [`PAINT_DIM][`PAINT_DIM]; // Indexed [y][x].
    coord_t      m_x;
    coord_t      m_y;
    color_t      m_color;
    logic        palette_mode;
    logic        c_held; // Set by a C pressed in the palette until a canvas check sees it.
    logic [31:0] lfsr;
    int          cycles = 0;

    paint_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .key       (key),
        .key_valid (key_valid),
        .pix       (pix),
        .pix_valid (pix_valid),
        .scan_done (scan_done)
    );

    always #50 clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            fail_run($sformatf("FAILED at %0t: %s, got %0h, expected %0h",
                               $time, what, actual, expected));
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            fail_run($sformatf("Timeout after %0d cycles, the DUT stopped finishing scans.",
                               cycles));
        end
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_key(output key_t k);
        for (int i = 0; i < 3; i++) begin
            lfsr = lfsr_next(lfsr); // One step per bit.
            k[i] = lfsr[0];
        end
    endtask

    task automatic apply_model(input key_t k);
        case (k)
            `PAINT_KEY_UP: begin
                if (m_y != 0) m_y = m_y - 1'b1;
            end
            `PAINT_KEY_DOWN: begin
                if (m_y != `PAINT_DIM - 1) m_y = m_y + 1'b1;
            end
            `PAINT_KEY_LEFT: begin
                if (m_x != 0) m_x = m_x - 1'b1;
            end
            `PAINT_KEY_RIGHT: begin
                if (m_x != `PAINT_DIM - 1) m_x = m_x + 1'b1;
            end
            `PAINT_KEY_C: begin
                if (palette_mode) begin
                    c_held = 1'b1;
                end else begin
                    palette_mode = 1'b1;
                end
            end
            `PAINT_KEY_ENTER: begin
                if (palette_mode) begin
                    m_color = {m_x, m_y};
                    // A held C reopens the palette right after the colour change.
                    if (c_held) begin
                        c_held = 1'b0;
                    end else begin
                        palette_mode = 1'b0;
                    end
                end else begin
                    canvas[m_y][m_x] = m_color;
                end
            end
            default: ; // Codes 6 and 7 only redraw.
        endcase
    endtask

    function automatic color_t expected_color(input coord_t x, input coord_t y);
        color_t base;
        base = palette_mode ? {x, y} : canvas[y][x];
        if (x == m_x && y == m_y) begin
            base = base ^ `PAINT_HILITE;
        end
        return base;
    endfunction

    // Follows one scan to its done pulse and compares every pixel with the model.
    task automatic check_scan();
        int     count;
        logic   done;
        coord_t x;
        coord_t y;
        count = 0;
        done  = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (pix_valid) begin
                if (count >= PIXELS) begin
                    fail_run("The scan streamed more pixels than the canvas holds.");
                end
                x = coord_t'(count % `PAINT_DIM);
                y = coord_t'(count / `PAINT_DIM);
                check_value(pix.x, x, "pixel x");
                check_value(pix.y, y, "pixel y");
                check_value(pix.color, expected_color(x, y),
                            $sformatf("colour at %0d,%0d", x, y));
                check_value(pix.last, count == PIXELS - 1, "last flag");
                count++;
            end else if (count > 0 && count < PIXELS) begin
                fail_run("The pixel stream paused in the middle of a scan.");
            end
            if (scan_done) begin
                check_value(count, PIXELS, "pixels in the scan");
                done = 1'b1;
            end
        end
    endtask

    task automatic send_key(input key_t k);
        @(negedge clk);
        key       = k;
        key_valid = 1'b1;
        @(negedge clk);
        key_valid = 1'b0;
    endtask

    task automatic press_key(input key_t k);
        send_key(k);
        apply_model(k);
        check_scan();
    endtask

    initial begin
        key_t k;
        rst          = 1'b1;
        key          = '0;
        key_valid    = 1'b0;
        lfsr         = SEED;
        m_x          = '0;
        m_y          = '0;
        m_color      = '0;
        palette_mode = 1'b0;
        c_held       = 1'b0;
        for (int y = 0; y < `PAINT_DIM; y++) begin
            for (int x = 0; x < `PAINT_DIM; x++) begin
                canvas[y][x] = '0;
            end
        end

        repeat (3) @(negedge clk);
        rst = 1'b0;
        check_value(pix_valid, 1'b0, "pix_valid after reset");
        check_value(scan_done, 1'b0, "scan_done after reset");

        // Blank canvas with the highlight at 0,0.
        check_scan();

        // Cursor moves and saturation on all four edges.
        press_key(`PAINT_KEY_LEFT);
        press_key(`PAINT_KEY_UP);
        repeat (17) press_key(`PAINT_KEY_RIGHT);
        repeat (17) press_key(`PAINT_KEY_DOWN);
        repeat (3) press_key(`PAINT_KEY_LEFT);
        press_key(`PAINT_KEY_UP);

        // Palette pick.
        press_key(`PAINT_KEY_C);
        repeat (3) press_key(`PAINT_KEY_LEFT);
        repeat (5) press_key(`PAINT_KEY_UP);
        press_key(`PAINT_KEY_ENTER);

        // Painting on the canvas.
        press_key(`PAINT_KEY_ENTER);
        press_key(`PAINT_KEY_LEFT);
        press_key(`PAINT_KEY_UP);
        press_key(`PAINT_KEY_ENTER);
        press_key(3'd6);
        press_key(3'd7);

        // C held in the palette keeps the palette open after Enter.
        press_key(`PAINT_KEY_C);
        press_key(`PAINT_KEY_RIGHT);
        press_key(`PAINT_KEY_C);
        press_key(`PAINT_KEY_ENTER);
        press_key(`PAINT_KEY_DOWN);
        press_key(`PAINT_KEY_ENTER);
        press_key(`PAINT_KEY_ENTER);

        for (int n = 0; n < RANDOM_KEYS; n++) begin
            random_key(k);
            press_key(k);
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+hdl
hdl/paint_pkg.sv
hdl/key_decoder.sv
hdl/cursor_tracker.sv
hdl/control_paint.sv
hdl/frame_buffer.sv
hdl/frame_scanner.sv
hdl/paint_top.sv
verif/tb_paint.sv

/* run_sim.sh */
#!/bin/sh
# Builds the paint design and its testbench with Verilator and runs the simulation.
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_paint -f sim.f \
    || { echo "Verilator build failed."; exit 1; }

./obj_dir/Vtb_paint > sim.log 2>&1
cat sim.log

grep -q "Testbench failed" sim.log && { echo "Simulation failed."; exit 1; }
grep -q "Testbench passed" sim.log || { echo "Simulation ended without a result."; exit 1; }
echo "Simulation passed."
